// ==== hw/border_consts.svh ====
`ifndef BORDER_CONSTS_SVH
`define BORDER_CONSTS_SVH

// number of independent fluxes sharing the datapath
`define BR_FLUX 2
`define BR_PEL_WIDTH 8
// row and column counts and counters
`define BR_SIZE_WIDTH 7
// border width in pixels and in rows
`define BR_N_TAP 8
// flux index bits, never below one
`define BR_TAG_WIDTH ((`BR_FLUX > 1) ? $clog2(`BR_FLUX) : 1)

`endif

// ==== hw/border_pkg.sv ====
`default_nettype none

`include "border_consts.svh"

package border_pkg;

    // per-flux frame phase
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        DROP_INIT = 2'd1,
        WORK      = 2'd2,
        DROP      = 2'd3
    } border_state_e;

    // one context entry, kept per flux
    typedef struct packed {
        border_state_e              state;
        logic [`BR_SIZE_WIDTH-1:0]  col_cnt;
        logic [`BR_SIZE_WIDTH-1:0]  row_cnt;
        logic [`BR_SIZE_WIDTH-1:0]  col_max;
        logic [`BR_SIZE_WIDTH-1:0]  row_max;
    } flux_ctx_t;

    // pixel tagged with its flux
    typedef struct packed {
        logic [`BR_TAG_WIDTH-1:0]   tag;
        logic [`BR_PEL_WIDTH-1:0]   pel;
    } out_word_t;

endpackage

`default_nettype wire

// ==== hw/flux_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "border_consts.svh"

module flux_arbiter
    import border_pkg::*;
(
    input  wire logic [`BR_FLUX-1:0]        pel_empty,
    input  wire logic [`BR_FLUX-1:0]        hdr_row_empty,
    input  wire logic [`BR_FLUX-1:0]        hdr_col_empty,
    input  wire logic [`BR_FLUX-1:0]        out_full,
    input  border_state_e [`BR_FLUX-1:0]    flux_states,
    input  wire logic                       hdr_req,
    input  wire logic                       pel_req,
    output logic [`BR_TAG_WIDTH-1:0]        sel,
    output logic                            sel_valid,
    output logic [`BR_FLUX-1:0]             pel_read,
    output logic [`BR_FLUX-1:0]             hdr_read
);

    localparam int TW = `BR_TAG_WIDTH;

    logic [`BR_FLUX-1:0] ready;

    // readiness per flux, depends on its phase
    always_comb
    begin
        for (int i = 0; i < `BR_FLUX; i++)
        begin
            case (flux_states[i])
                IDLE:      ready[i] = !hdr_row_empty[i] && !hdr_col_empty[i];
                DROP_INIT: ready[i] = !pel_empty[i];
                WORK:      ready[i] = !pel_empty[i] && !out_full[i];
                DROP:      ready[i] = !pel_empty[i];
                default:   ready[i] = 1'b0;
            endcase
        end
    end

    // scan downwards so the lowest ready index wins
    always_comb
    begin
        sel       = '0;
        sel_valid = 1'b0;
        for (int i = `BR_FLUX - 1; i >= 0; i--)
        begin
            if (ready[i])
            begin
                sel       = TW'(i);
                sel_valid = 1'b1;
            end
        end
    end

    // strobes go to the selected flux only
    always_comb
    begin
        for (int i = 0; i < `BR_FLUX; i++)
        begin
            pel_read[i] = sel_valid && (sel == TW'(i)) && pel_req;
            hdr_read[i] = sel_valid && (sel == TW'(i)) && hdr_req;
        end
    end

endmodule

`default_nettype wire

// ==== hw/flux_context_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "border_consts.svh"

module flux_context_ram
    import border_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic [`BR_TAG_WIDTH-1:0]   sel,
    input  wire logic                       ctx_we,
    input  flux_ctx_t                       ctx_wr,
    output flux_ctx_t                       ctx_rd,
    output border_state_e [`BR_FLUX-1:0]    flux_states
);

    flux_ctx_t ctx_mem [`BR_FLUX];

    // all fluxes start idle with cleared counters
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `BR_FLUX; i++)
            begin
                ctx_mem[i] <= '{
                    state:   IDLE,
                    col_cnt: '0,
                    row_cnt: '0,
                    col_max: '0,
                    row_max: '0
                };
            end
        end
        else if (ctx_we)
        begin
            ctx_mem[sel] <= ctx_wr;
        end
    end

    // read port is asynchronous
    assign ctx_rd = ctx_mem[sel];

    // phases of every flux, for readiness
    always_comb
    begin
        for (int i = 0; i < `BR_FLUX; i++)
        begin
            flux_states[i] = ctx_mem[i].state;
        end
    end

endmodule

`default_nettype wire

// ==== hw/border_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "border_consts.svh"

module border_fsm
    import border_pkg::*;
(
    input  wire logic [`BR_TAG_WIDTH-1:0]   sel,
    input  wire logic                       sel_valid,
    input  flux_ctx_t                       ctx_rd,
    input  wire logic [`BR_PEL_WIDTH-1:0]   pel_in,
    input  wire logic [`BR_SIZE_WIDTH-1:0]  row_in,
    input  wire logic [`BR_SIZE_WIDTH-1:0]  col_in,
    output flux_ctx_t                       ctx_wr,
    output logic                            ctx_we,
    output logic                            hdr_req,
    output logic                            pel_req,
    output out_word_t                       out_data,
    output logic                            out_write
);

    localparam int SW = `BR_SIZE_WIDTH;
    localparam logic [SW-1:0] TAP_LAST = SW'(`BR_N_TAP - 1);

    logic [SW-1:0] col_last;
    logic [SW-1:0] work_row_last;
    logic          row_end;

    // last column index and last passed row index of the frame
    assign col_last      = ctx_rd.col_max - SW'(1);
    assign work_row_last = ctx_rd.row_max - SW'(`BR_N_TAP + 1);
    assign row_end       = (ctx_rd.col_cnt == col_last);

    // context advances whenever some flux is served
    assign ctx_we = sel_valid;

    // pixel goes out as is, tagged with the flux
    assign out_data.tag = sel;
    assign out_data.pel = pel_in;

    always_comb
    begin
        ctx_wr    = ctx_rd;
        hdr_req   = 1'b0;
        pel_req   = 1'b0;
        out_write = 1'b0;

        if (sel_valid)
        begin
            case (ctx_rd.state)
                IDLE:
                begin
                    // both headers taken in one go
                    hdr_req        = 1'b1;
                    ctx_wr.state   = DROP_INIT;
                    ctx_wr.col_cnt = '0;
                    ctx_wr.row_cnt = '0;
                    ctx_wr.col_max = col_in;
                    ctx_wr.row_max = row_in;
                end

                DROP_INIT:
                begin
                    // leading N_TAP pixels, counted in row_cnt
                    pel_req = 1'b1;
                    if (ctx_rd.row_cnt == TAP_LAST)
                    begin
                        ctx_wr.state   = WORK;
                        ctx_wr.row_cnt = '0;
                    end
                    else
                    begin
                        ctx_wr.row_cnt = ctx_rd.row_cnt + SW'(1);
                    end
                end

                WORK:
                begin
                    pel_req   = 1'b1;
                    out_write = 1'b1;
                    if (!row_end)
                    begin
                        ctx_wr.col_cnt = ctx_rd.col_cnt + SW'(1);
                    end
                    else if (ctx_rd.row_cnt == work_row_last)
                    begin
                        // last passed row done, bottom border follows
                        ctx_wr.state   = DROP;
                        ctx_wr.col_cnt = '0;
                        ctx_wr.row_cnt = '0;
                    end
                    else
                    begin
                        ctx_wr.col_cnt = '0;
                        ctx_wr.row_cnt = ctx_rd.row_cnt + SW'(1);
                    end
                end

                DROP:
                begin
                    pel_req = 1'b1;
                    if (!row_end)
                    begin
                        ctx_wr.col_cnt = ctx_rd.col_cnt + SW'(1);
                    end
                    else if (ctx_rd.row_cnt == TAP_LAST)
                    begin
                        // frame over
                        ctx_wr.state   = IDLE;
                        ctx_wr.col_cnt = '0;
                        ctx_wr.row_cnt = '0;
                        ctx_wr.col_max = '0;
                        ctx_wr.row_max = '0;
                    end
                    else
                    begin
                        ctx_wr.col_cnt = '0;
                        ctx_wr.row_cnt = ctx_rd.row_cnt + SW'(1);
                    end
                end

                default:
                begin
                    ctx_wr.state = IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/border_remover.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "border_consts.svh"

module border_remover
    import border_pkg::*;
(
    input  wire logic                                       clk,
    input  wire logic                                       rst,
    input  wire logic [`BR_FLUX-1:0]                        pel_empty,
    output logic [`BR_FLUX-1:0]                             pel_read,
    input  wire logic [`BR_FLUX-1:0][`BR_PEL_WIDTH-1:0]     pel_data,
    input  wire logic [`BR_FLUX-1:0]                        hdr_row_empty,
    input  wire logic [`BR_FLUX-1:0]                        hdr_col_empty,
    output logic [`BR_FLUX-1:0]                             hdr_read,
    input  wire logic [`BR_FLUX-1:0][`BR_SIZE_WIDTH-1:0]    hdr_row_data,
    input  wire logic [`BR_FLUX-1:0][`BR_SIZE_WIDTH-1:0]    hdr_col_data,
    input  wire logic [`BR_FLUX-1:0]                        out_full,
    output logic [`BR_FLUX-1:0]                             out_write,
    output out_word_t                                       out_data
);

    localparam int TW = `BR_TAG_WIDTH;

    logic [TW-1:0]                  sel;
    logic                           sel_valid;
    logic                           hdr_req;
    logic                           pel_req;
    logic                           fsm_write;
    logic                           ctx_we;
    flux_ctx_t                      ctx_rd;
    flux_ctx_t                      ctx_wr;
    border_state_e [`BR_FLUX-1:0]   flux_states;

    flux_arbiter u_arbiter (
        .pel_empty     (pel_empty),
        .hdr_row_empty (hdr_row_empty),
        .hdr_col_empty (hdr_col_empty),
        .out_full      (out_full),
        .flux_states   (flux_states),
        .hdr_req       (hdr_req),
        .pel_req       (pel_req),
        .sel           (sel),
        .sel_valid     (sel_valid),
        .pel_read      (pel_read),
        .hdr_read      (hdr_read)
    );

    flux_context_ram u_ctx_ram (
        .clk         (clk),
        .rst         (rst),
        .sel         (sel),
        .ctx_we      (ctx_we),
        .ctx_wr      (ctx_wr),
        .ctx_rd      (ctx_rd),
        .flux_states (flux_states)
    );

    // selected flux data straight into the fsm
    border_fsm u_fsm (
        .sel       (sel),
        .sel_valid (sel_valid),
        .ctx_rd    (ctx_rd),
        .pel_in    (pel_data[sel]),
        .row_in    (hdr_row_data[sel]),
        .col_in    (hdr_col_data[sel]),
        .ctx_wr    (ctx_wr),
        .ctx_we    (ctx_we),
        .hdr_req   (hdr_req),
        .pel_req   (pel_req),
        .out_data  (out_data),
        .out_write (fsm_write)
    );

    // write strobe only toward the served flux
    always_comb
    begin
        for (int i = 0; i < `BR_FLUX; i++)
        begin
            out_write[i] = fsm_write && (sel == TW'(i));
        end
    end

endmodule

`default_nettype wire

// ==== tb/border_model.svh ====
`ifndef BORDER_MODEL_SVH
`define BORDER_MODEL_SVH

`include "border_consts.svh"

typedef logic [`BR_PEL_WIDTH-1:0]  pel_word_t;
typedef logic [`BR_SIZE_WIDTH-1:0] size_word_t;

// expected output pixels per flux, oldest first
pel_word_t exp_q [`BR_FLUX][$];

// open frame per flux, no pixels left means idle
int frame_left [`BR_FLUX];
int frame_pos  [`BR_FLUX];
int cur_rows   [`BR_FLUX];
int cur_cols   [`BR_FLUX];

// input pixels taken by one frame
function automatic int frame_length(int rows, int cols);
    return `BR_N_TAP + rows * cols;
endfunction

// pixel k of a frame goes out if past the leading taps and above the bottom border
function automatic bit pel_passes(int k, int rows, int cols);
    return (k >= `BR_N_TAP) && (k < `BR_N_TAP + (rows - `BR_N_TAP) * cols);
endfunction

function automatic void expect_frame(int f, int rows, int cols, pel_word_t frame [$]);
    for (int k = 0; k < frame.size(); k++)
    begin
        if (pel_passes(k, rows, cols))
        begin
            exp_q[f].push_back(frame[k]);
        end
    end
endfunction

function automatic void start_frame(int f, int rows, int cols);
    cur_rows[f]   = rows;
    cur_cols[f]   = cols;
    frame_pos[f]  = 0;
    frame_left[f] = frame_length(rows, cols);
endfunction

function automatic bit next_pel_passes(int f);
    return (frame_left[f] > 0) && pel_passes(frame_pos[f], cur_rows[f], cur_cols[f]);
endfunction

function automatic void consume_pel(int f);
    frame_pos[f]++;
    frame_left[f]--;
endfunction

// idle needs both headers, a passed pixel also needs room at the output
function automatic bit flux_ready(int f, logic [`BR_FLUX-1:0] pe, logic [`BR_FLUX-1:0] hre,
                                  logic [`BR_FLUX-1:0] hce, logic [`BR_FLUX-1:0] of);
    if (frame_left[f] == 0)
    begin
        return !hre[f] && !hce[f];
    end
    if (next_pel_passes(f))
    begin
        return !pe[f] && !of[f];
    end
    return !pe[f];
endfunction

// lowest ready flux, or -1 when none can move
function automatic int pick_flux(logic [`BR_FLUX-1:0] pe, logic [`BR_FLUX-1:0] hre,
                                 logic [`BR_FLUX-1:0] hce, logic [`BR_FLUX-1:0] of);
    for (int f = 0; f < `BR_FLUX; f++)
    begin
        if (flux_ready(f, pe, hre, hce, of))
        begin
            return f;
        end
    end
    return -1;
endfunction

function automatic int count_ready(logic [`BR_FLUX-1:0] pe, logic [`BR_FLUX-1:0] hre,
                                   logic [`BR_FLUX-1:0] hce, logic [`BR_FLUX-1:0] of);
    int n;
    n = 0;
    for (int f = 0; f < `BR_FLUX; f++)
    begin
        n += int'(flux_ready(f, pe, hre, hce, of));
    end
    return n;
endfunction

function automatic void clear_model();
    for (int f = 0; f < `BR_FLUX; f++)
    begin
        exp_q[f].delete();
        frame_left[f] = 0;
        frame_pos[f]  = 0;
    end
endfunction

`endif

// ==== tb/border_remover_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "border_consts.svh"

module border_remover_tb
    import border_pkg::*;
();

    localparam int TW = `BR_TAG_WIDTH;

    logic                                       clk;
    logic                                       rst;
    logic [`BR_FLUX-1:0]                        pel_empty;
    logic [`BR_FLUX-1:0]                        pel_read;
    logic [`BR_FLUX-1:0][`BR_PEL_WIDTH-1:0]     pel_data;
    logic [`BR_FLUX-1:0]                        hdr_row_empty;
    logic [`BR_FLUX-1:0]                        hdr_col_empty;
    logic [`BR_FLUX-1:0]                        hdr_read;
    logic [`BR_FLUX-1:0][`BR_SIZE_WIDTH-1:0]    hdr_row_data;
    logic [`BR_FLUX-1:0][`BR_SIZE_WIDTH-1:0]    hdr_col_data;
    logic [`BR_FLUX-1:0]                        out_full;
    logic [`BR_FLUX-1:0]                        out_write;
    out_word_t                                  out_data;

    `include "border_model.svh"

    // emulated input FIFOs
    pel_word_t  pel_q [`BR_FLUX][$];
    size_word_t row_q [`BR_FLUX][$];
    size_word_t col_q [`BR_FLUX][$];

    integer              seed;
    string               cur_test;
    int                  test_errors;
    int                  errors;
    int                  tests_run;
    int                  tests_failed;
    int                  tie_cycles;
    bit                  abort;
    logic [`BR_FLUX-1:0] hold_full;
    int                  out_cnt  [`BR_FLUX];
    int                  want_cnt [`BR_FLUX];

    border_remover dut (
        .clk           (clk),
        .rst           (rst),
        .pel_empty     (pel_empty),
        .pel_read      (pel_read),
        .pel_data      (pel_data),
        .hdr_row_empty (hdr_row_empty),
        .hdr_col_empty (hdr_col_empty),
        .hdr_read      (hdr_read),
        .hdr_row_data  (hdr_row_data),
        .hdr_col_data  (hdr_col_data),
        .out_full      (out_full),
        .out_write     (out_write),
        .out_data      (out_data)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    function automatic int rand_between(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic report_mismatch(string what, logic [31:0] want, logic [31:0] got);
        $display("Error %s: %s expected %0h, actual %0h", cur_test, what, want, got);
        test_errors++;
    endtask

    task automatic report_problem(string msg);
        $display("%s: %s", cur_test, msg);
        test_errors++;
    endtask

    // FIFO status from queue contents with random gaps
    task automatic drive_inputs();
        for (int f = 0; f < `BR_FLUX; f++)
        begin
            pel_empty[f]     = (pel_q[f].size() == 0) || (($random(seed) & 3) == 0);
            hdr_row_empty[f] = (row_q[f].size() == 0) || (($random(seed) & 7) == 0);
            hdr_col_empty[f] = (col_q[f].size() == 0) || (($random(seed) & 7) == 0);
            pel_data[f]      = (pel_q[f].size() != 0) ? pel_q[f][0] : '0;
            hdr_row_data[f]  = (row_q[f].size() != 0) ? row_q[f][0] : '0;
            hdr_col_data[f]  = (col_q[f].size() != 0) ? col_q[f][0] : '0;
            out_full[f]      = hold_full[f] || (($random(seed) & 3) == 0);
        end
    endtask

    task automatic check_cycle();
        int                  pick;
        logic [`BR_FLUX-1:0] want_hdr;
        logic [`BR_FLUX-1:0] want_pel;
        logic [`BR_FLUX-1:0] want_wr;
        pel_word_t           want_word;
        want_hdr = '0;
        want_pel = '0;
        want_wr  = '0;
        pick = pick_flux(pel_empty, hdr_row_empty, hdr_col_empty, out_full);
        if (count_ready(pel_empty, hdr_row_empty, hdr_col_empty, out_full) > 1)
        begin
            tie_cycles++;
        end
        if (pick >= 0 && frame_left[pick] == 0)
        begin
            want_hdr[pick] = 1'b1;
        end
        else if (pick >= 0)
        begin
            want_pel[pick] = 1'b1;
            want_wr[pick]  = next_pel_passes(pick);
        end
        assert (hdr_read === want_hdr)
        else report_mismatch("header read", 32'(want_hdr), 32'(hdr_read));
        assert (pel_read === want_pel)
        else report_mismatch("pixel read", 32'(want_pel), 32'(pel_read));
        assert (out_write === want_wr)
        else report_mismatch("out write", 32'(want_wr), 32'(out_write));
        for (int f = 0; f < `BR_FLUX; f++)
        begin
            // a stalled flux keeps its pixel
            if (out_full[f] && next_pel_passes(f))
            begin
                assert (!pel_read[f])
                else report_problem("pixel read while its output was full");
            end
            if (out_write[f])
            begin
                out_cnt[f]++;
                assert (!out_full[f])
                else report_problem("word written into a full output FIFO");
                assert (out_data.tag == TW'(f))
                else report_mismatch("tag", f, 32'(out_data.tag));
                assert (exp_q[f].size() != 0)
                else report_problem("output word with no expected pixel left");
                if (exp_q[f].size() != 0)
                begin
                    want_word = exp_q[f].pop_front();
                    assert (out_data.pel === want_word)
                    else report_mismatch("pixel", 32'(want_word), 32'(out_data.pel));
                end
            end
            if (hdr_read[f])
            begin
                assert (frame_left[f] == 0 && row_q[f].size() != 0)
                else report_problem("header read while a frame was open or none was queued");
                if (row_q[f].size() != 0)
                begin
                    start_frame(f, row_q[f].pop_front(), col_q[f].pop_front());
                end
            end
            if (pel_read[f])
            begin
                assert (!pel_empty[f] && frame_left[f] > 0)
                else report_problem("pixel read from an empty FIFO");
                if (pel_q[f].size() != 0)
                begin
                    void'(pel_q[f].pop_front());
                end
                if (frame_left[f] > 0)
                begin
                    consume_pel(f);
                end
            end
        end
    endtask

    // drive on the falling edge and sample just before the rising one
    task automatic step();
        @(negedge clk);
        drive_inputs();
        #4;
        check_cycle();
    endtask

    task automatic add_frame(int f, int rows, int cols);
        pel_word_t frame [$];
        for (int k = 0; k < frame_length(rows, cols); k++)
        begin
            frame.push_back(pel_word_t'($random(seed)));
        end
        expect_frame(f, rows, cols, frame);
        row_q[f].push_back(size_word_t'(rows));
        col_q[f].push_back(size_word_t'(cols));
        foreach (frame[k])
        begin
            pel_q[f].push_back(frame[k]);
        end
        want_cnt[f] += (rows - `BR_N_TAP) * cols;
    endtask

    function automatic bit fluxes_done(logic [`BR_FLUX-1:0] mask);
        for (int f = 0; f < `BR_FLUX; f++)
        begin
            if (mask[f] && (pel_q[f].size() != 0 || row_q[f].size() != 0 || frame_left[f] != 0))
            begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_done(logic [`BR_FLUX-1:0] mask, int limit);
        int cycles;
        cycles = 0;
        while (!fluxes_done(mask) && cycles < limit)
        begin
            step();
            cycles++;
        end
        assert (fluxes_done(mask)) else
        begin
            report_problem($sformatf("timeout, fluxes %b still busy after %0d cycles", mask, limit));
            abort = 1'b1;
        end
    endtask

    task automatic begin_test(string name);
        cur_test    = name;
        test_errors = 0;
        tie_cycles  = 0;
        for (int f = 0; f < `BR_FLUX; f++)
        begin
            out_cnt[f]  = 0;
            want_cnt[f] = 0;
        end
    endtask

    // every flux drained with the right number of words
    task automatic check_counts();
        for (int f = 0; f < `BR_FLUX; f++)
        begin
            assert (out_cnt[f] == want_cnt[f])
            else report_mismatch("word count", want_cnt[f], out_cnt[f]);
            assert (exp_q[f].size() == 0 && pel_q[f].size() == 0 && row_q[f].size() == 0)
            else report_problem($sformatf("flux %0d left items behind", f));
        end
    endtask

    task automatic end_test();
        tests_run++;
        errors += test_errors;
        if (test_errors != 0)
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, test_errors);
        end
        else
        begin
            $display("test %s: passed", cur_test);
        end
    endtask

    initial
    begin
        seed          = 32'h37cc;
        rst           = 1'b1;
        hold_full     = '0;
        pel_empty     = '1;
        hdr_row_empty = '1;
        hdr_col_empty = '1;
        out_full      = '0;
        pel_data      = '0;
        hdr_row_data  = '0;
        hdr_col_data  = '0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        abort         = 1'b0;
        clear_model();
        #1;

        // reset spans four rising edges and one cycle out of it
        begin_test("reset");
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            rst = (i < 3);
            drive_inputs();
            #4;
            assert ({pel_read, hdr_read, out_write} === '0)
            else report_mismatch("strobes", 0, 32'({pel_read, hdr_read, out_write}));
            check_cycle();
        end
        end_test();

        begin_test("single flux frame");
        add_frame(0, rand_between(`BR_N_TAP + 1, 20), rand_between(1, 10));
        wait_done('1, 2000);
        check_counts();
        end_test();

        if (!abort)
        begin
            begin_test("interleaved fluxes");
            for (int f = 0; f < `BR_FLUX; f++)
            begin
                add_frame(f, rand_between(`BR_N_TAP + 1, 20), rand_between(1, 10));
            end
            wait_done('1, 4000);
            check_counts();
            assert (`BR_FLUX == 1 || tie_cycles > 0)
            else report_problem("no cycle had several fluxes ready");
            end_test();
        end

        if (!abort)
        begin
            begin_test("back-pressure");
            hold_full = 1;
            for (int f = 0; f < `BR_FLUX; f++)
            begin
                add_frame(f, rand_between(`BR_N_TAP + 1, 20), rand_between(1, 10));
            end
            wait_done('1 << 1, 4000);
            for (int i = 0; i < 30; i++)
            begin
                step();
            end
            assert (out_cnt[0] == 0) else report_mismatch("held flux words", 0, out_cnt[0]);
            hold_full = '0;
            wait_done('1, 2000);
            check_counts();
            end_test();
        end

        if (!abort)
        begin
            begin_test("back-to-back frames");
            for (int i = 0; i < 3; i++)
            begin
                add_frame(0, `BR_N_TAP + 1 + 3 * i + rand_between(0, 2), rand_between(1, 10));
            end
            wait_done('1, 6000);
            check_counts();
            end_test();
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && !abort)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
+incdir+tb
hw/border_pkg.sv
hw/flux_arbiter.sv
hw/flux_context_ram.sv
hw/border_fsm.sv
hw/border_remover.sv
tb/border_remover_tb.sv
